// File: vlog.f
hw/cache_pkg.sv
hw/cache_tag_store.sv
hw/icache_ctrl.sv
hw/dcache_ctrl.sv
hw/dmem_controller.sv
hw/cache_sim.sv
bench/cache_sim_properties.sv
bench/cache_sim_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/100ps
TOP       = cache_sim_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = === FAIL ===
PASS_MSG  = === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/cache_sim_patterns.txt
# Columns: port pc read write mask lane0 lane1 lane2 lane3 istall dstall (hex, stalls decimal)
# Port I is fetch, D is data, B is both; read and write are mem_op_t codes, 7 means none.
# Cold fetch, then hits in the same block.
I 00000100 7 7 0 00000000 00000000 00000000 00000000 3 0
I 00000100 7 7 0 00000000 00000000 00000000 00000000 0 0
I 0000010c 7 7 0 00000000 00000000 00000000 00000000 0 0
# Conflicting index 0 with another tag, then the first PC again.
I 00000200 7 7 0 00000000 00000000 00000000 00000000 3 0
I 00000100 7 7 0 00000000 00000000 00000000 00000000 3 0
I 00000104 7 7 0 00000000 00000000 00000000 00000000 0 0
# Four lanes in one cold block, then the same request.
D 00000000 2 7 f 00001000 00001004 00001008 0000100c 0 3
D 00000000 2 7 f 00001000 00001004 00001008 0000100c 0 0
# Three cold blocks, lane 3 shares the block of lane 1.
D 00000000 0 7 f 00002000 00002010 00002020 00002014 0 9
# Invalid lanes and no operation.
D 00000000 2 7 0 00003000 00003010 00003020 00003030 0 0
D 00000000 2 7 1 00002000 00003010 00003020 00003030 0 0
D 00000000 7 7 f 00004000 00004010 00004020 00004030 0 0
# Lanes 0 and 1 on index 3 with different tags.
D 00000000 1 7 3 00005030 00006030 00000000 00000000 0 6
# Store allocates, the load after it hits.
D 00000000 7 2 1 00007040 00000000 00000000 00000000 0 3
D 00000000 5 7 1 00007044 00000000 00000000 00000000 0 0
# Fetch and data side by side.
B 00000300 2 7 f 00008050 00008060 00008070 00008054 3 9
B 00000300 2 7 1 00008050 00000000 00000000 00000000 0 0
B 00000410 4 7 1 00009080 00000000 00000000 00000000 3 3
# Blocks evicted earlier miss again.
D 00000000 4 7 1 00001000 00000000 00000000 00000000 0 3
I 00000100 7 7 0 00000000 00000000 00000000 00000000 3 0

// File: bench/cache_sim_tb.sv
module cache_sim_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import cache_pkg::*;

	localparam int MAX_PATTERNS = 64;

	logic          clk;
	logic          reset;
	addr_t         icache_pc_addr;
	logic          icache_valid_pc_addr;
	logic          icache_stall;
	mem_op_t       dcache_mem_read;
	mem_op_t       dcache_mem_write;
	logic [NT-1:0] dcache_in_valid;
	addr_t         dcache_in_addr [NT];
	logic          dcache_stall;

	byte           pat_port   [MAX_PATTERNS];
	addr_t         pat_pc     [MAX_PATTERNS];
	mem_op_t       pat_read   [MAX_PATTERNS];
	mem_op_t       pat_write  [MAX_PATTERNS];
	logic [NT-1:0] pat_mask   [MAX_PATTERNS];
	addr_t         pat_lane   [MAX_PATTERNS][NT];
	int            pat_istall [MAX_PATTERNS];
	int            pat_dstall [MAX_PATTERNS];
	int            pat_gap    [MAX_PATTERNS];
	int            pat_count   = 0;
	int            cycle_count = 0;
	int            cycle_limit = 0;

	cache_sim i_cache_sim (
		.clk                 (clk),
		.reset               (reset),
		.icache_pc_addr      (icache_pc_addr),
		.icache_valid_pc_addr(icache_valid_pc_addr),
		.icache_stall        (icache_stall),
		.dcache_mem_read     (dcache_mem_read),
		.dcache_mem_write    (dcache_mem_write),
		.dcache_in_valid     (dcache_in_valid),
		.dcache_in_addr      (dcache_in_addr),
		.dcache_stall        (dcache_stall)
	);

	bind dmem_controller cache_sim_properties i_properties (
		.clk              (clk),
		.reset            (reset),
		.icache_dram_req  (icache_dram_req),
		.dcache_dram_req  (dcache_dram_req),
		.icache_dram_ready(icache_dram_ready),
		.dcache_dram_ready(dcache_dram_ready)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period.

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
			fail_run($sformatf("Timeout: the run went past %0d cycles", cycle_limit));
		if (i_cache_sim.i_dmem_controller.i_properties.failures != 0)
			fail_run("A DRAM handshake assertion failed");
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_icache_stall(input logic got, input logic expected, input int req,
			input int cycle);
		if (got !== expected)
			fail_run({$sformatf("MISMATCH at %0d ns: icache_stall, request %0d cycle %0d,",
				$time, req, cycle), $sformatf(" got %b expected %b", got, expected)});
	endtask

	task automatic check_dcache_stall(input logic got, input logic expected, input int req,
			input int cycle);
		if (got !== expected)
			fail_run({$sformatf("MISMATCH at %0d ns: dcache_stall, request %0d cycle %0d,",
				$time, req, cycle), $sformatf(" got %b expected %b", got, expected)});
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic read_patterns();
		int          fd;
		int          fields;
		string       line;
		byte         port;
		logic [31:0] pc;
		logic [31:0] rd;
		logic [31:0] wr;
		logic [31:0] mask;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		int          istall;
		int          dstall;
		fd = $fopen("bench/cache_sim_patterns.txt", "r");
		if (fd == 0)
			fail_run("Could not open bench/cache_sim_patterns.txt");
		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0)
				continue;
			if (line.len() < 3 || line.getc(0) == "#")
				continue; // Blank or comment line.
			fields = $sscanf(line, "%c %h %h %h %h %h %h %h %h %d %d", port, pc, rd, wr, mask,
				a0, a1, a2, a3, istall, dstall);
			if (fields != 11)
				fail_run({"Malformed pattern line: ", line});
			if (pat_count == MAX_PATTERNS)
				fail_run("Pattern file holds more lines than the bench can store");
			pat_port[pat_count]    = port;
			pat_pc[pat_count]      = pc;
			pat_read[pat_count]    = mem_op_t'(rd[2:0]);
			pat_write[pat_count]   = mem_op_t'(wr[2:0]);
			pat_mask[pat_count]    = mask[NT-1:0];
			pat_lane[pat_count][0] = a0;
			pat_lane[pat_count][1] = a1;
			pat_lane[pat_count][2] = a2;
			pat_lane[pat_count][3] = a3;
			pat_istall[pat_count]  = istall;
			pat_dstall[pat_count]  = dstall;
			pat_count++;
		end
		$fclose(fd);
	endtask

	// Idle gaps of 0 to 3 cycles, and a cycle budget from the expected stalls.
	task automatic schedule_gaps();
		logic [31:0] seed;
		int          longest;
		seed        = 32'd60;
		cycle_limit = 8 + 50;
		for (int k = 0; k < pat_count; k++) begin
			seed       = xorshift32(seed);
			pat_gap[k] = int'(seed[1:0]);
			longest    = (pat_istall[k] > pat_dstall[k]) ? pat_istall[k] : pat_dstall[k];
			cycle_limit += longest + 2 + pat_gap[k];
		end
	endtask

	task automatic drive_idle();
		icache_pc_addr       = '0;
		icache_valid_pc_addr = 1'b0;
		dcache_mem_read      = MEM_NONE;
		dcache_mem_write     = MEM_NONE;
		dcache_in_valid      = '0;
		for (int l = 0; l < NT; l++)
			dcache_in_addr[l] = '0;
	endtask

	task automatic run_request(input int k);
		int last;
		last = (pat_istall[k] > pat_dstall[k]) ? pat_istall[k] : pat_dstall[k];
		@(negedge clk);
		drive_idle();
		if (pat_port[k] == "I" || pat_port[k] == "B") begin
			icache_pc_addr       = pat_pc[k];
			icache_valid_pc_addr = 1'b1;
		end
		if (pat_port[k] == "D" || pat_port[k] == "B") begin
			dcache_mem_read  = pat_read[k];
			dcache_mem_write = pat_write[k];
			dcache_in_valid  = pat_mask[k];
			for (int l = 0; l < NT; l++)
				dcache_in_addr[l] = pat_lane[k][l];
		end
		for (int c = 0; c <= last; c++) begin
			#1; // Just before the rising edge.
			check_icache_stall(icache_stall, c < pat_istall[k], k, c);
			check_dcache_stall(dcache_stall, c < pat_dstall[k], k, c);
			if (c < last) begin
				@(negedge clk);
				if (c >= pat_istall[k])
					icache_valid_pc_addr = 1'b0; // Fetch side is served.
				if (c >= pat_dstall[k]) begin
					dcache_mem_read  = MEM_NONE;
					dcache_mem_write = MEM_NONE;
					dcache_in_valid  = '0;
				end
			end
		end
	endtask

	task automatic idle_gap(input int k);
		repeat (pat_gap[k]) begin
			@(negedge clk);
			drive_idle();
			#1;
			check_icache_stall(icache_stall, 1'b0, k, -1);
			check_dcache_stall(dcache_stall, 1'b0, k, -1);
		end
	endtask

	initial begin
		reset = 1'b1;
		drive_idle();
		read_patterns();
		schedule_gaps();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		check_icache_stall(icache_stall, 1'b0, -1, -1); // No request, no stall.
		check_dcache_stall(dcache_stall, 1'b0, -1, -1);
		for (int k = 0; k < pat_count; k++) begin
			run_request(k);
			idle_gap(k);
		end
		@(negedge clk);
		if (i_cache_sim.i_dmem_controller.i_properties.failures == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			fail_run("A DRAM handshake assertion failed");
		end
	end

endmodule

// File: bench/cache_sim_properties.sv
module cache_sim_properties (
	input logic                 clk,
	input logic                 reset,
	input cache_pkg::dram_req_t icache_dram_req,
	input cache_pkg::dram_req_t dcache_dram_req,
	input logic                 icache_dram_ready,
	input logic                 dcache_dram_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures; // Failed assertions so far.

	// Request strobes last a single cycle.
	icache_valid_single: assert property (@(posedge clk) disable iff (reset)
		icache_dram_req.valid |=> !icache_dram_req.valid)
		else begin
			$error("icache DRAM request strobe held for two cycles");
			failures++;
		end

	dcache_valid_single: assert property (@(posedge clk) disable iff (reset)
		dcache_dram_req.valid |=> !dcache_dram_req.valid)
		else begin
			$error("dcache DRAM request strobe held for two cycles");
			failures++;
		end

	icache_ready_after_valid: assert property (@(posedge clk) disable iff (reset)
		icache_dram_ready |-> $past(icache_dram_req.valid))
		else begin
			$error("icache DRAM ready without a request in the cycle before");
			failures++;
		end

	dcache_ready_after_valid: assert property (@(posedge clk) disable iff (reset)
		dcache_dram_ready |-> $past(dcache_dram_req.valid))
		else begin
			$error("dcache DRAM ready without a request in the cycle before");
			failures++;
		end

	// Nothing goes out to memory during reset.
	no_valid_in_reset: assert property (@(posedge clk)
		reset |-> (!icache_dram_req.valid && !dcache_dram_req.valid))
		else begin
			$error("DRAM request raised while reset is active");
			failures++;
		end

endmodule

// File: hw/cache_sim.sv
module cache_sim #(
	parameter int NT           = cache_pkg::NT,
	parameter int ICACHE_LINES = cache_pkg::ICACHE_LINES,
	parameter int DCACHE_LINES = cache_pkg::DCACHE_LINES
) (
	input  logic               clk,
	input  logic               reset,

	// Fetch side.
	input  cache_pkg::addr_t   icache_pc_addr,
	input  logic               icache_valid_pc_addr,
	output logic               icache_stall,

	// Data side.
	input  cache_pkg::mem_op_t dcache_mem_read,
	input  cache_pkg::mem_op_t dcache_mem_write,
	input  logic [NT-1:0]      dcache_in_valid,
	input  cache_pkg::addr_t   dcache_in_addr [NT],
	output logic               dcache_stall
);
	import cache_pkg::*;

	dram_req_t icache_dram_req;
	dram_req_t dcache_dram_req;
	logic      icache_dram_ready;
	logic      dcache_dram_ready;

	dmem_controller #(
		.NT          (NT),
		.ICACHE_LINES(ICACHE_LINES),
		.DCACHE_LINES(DCACHE_LINES)
	) i_dmem_controller (
		.clk                 (clk),
		.reset               (reset),
		.icache_pc_addr      (icache_pc_addr),
		.icache_valid_pc_addr(icache_valid_pc_addr),
		.icache_stall        (icache_stall),
		.dcache_mem_read     (dcache_mem_read),
		.dcache_mem_write    (dcache_mem_write),
		.dcache_in_valid     (dcache_in_valid),
		.dcache_in_addr      (dcache_in_addr),
		.dcache_stall        (dcache_stall),
		.icache_dram_req     (icache_dram_req),
		.dcache_dram_req     (dcache_dram_req),
		.icache_dram_ready   (icache_dram_ready),
		.dcache_dram_ready   (dcache_dram_ready)
	);

	// Memory model: every request is answered one cycle later.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			icache_dram_ready <= 1'b0;
			dcache_dram_ready <= 1'b0;
		end else begin
			icache_dram_ready <= icache_dram_req.valid; // Strobe is one cycle, so is ready.
			dcache_dram_ready <= dcache_dram_req.valid;
		end
	end

endmodule

// File: hw/dmem_controller.sv
module dmem_controller #(
	parameter int NT           = 4,
	parameter int ICACHE_LINES = 16,
	parameter int DCACHE_LINES = 16
) (
	input  logic                 clk,
	input  logic                 reset,
	input  cache_pkg::addr_t     icache_pc_addr,
	input  logic                 icache_valid_pc_addr,
	output logic                 icache_stall,
	input  cache_pkg::mem_op_t   dcache_mem_read,
	input  cache_pkg::mem_op_t   dcache_mem_write,
	input  logic [NT-1:0]        dcache_in_valid,
	input  cache_pkg::addr_t     dcache_in_addr [NT],
	output logic                 dcache_stall,
	output cache_pkg::dram_req_t icache_dram_req,
	output cache_pkg::dram_req_t dcache_dram_req,
	input  logic                 icache_dram_ready,
	input  logic                 dcache_dram_ready
);

	icache_ctrl #(
		.LINES(ICACHE_LINES)
	) i_icache (
		.clk       (clk),
		.reset     (reset),
		.pc_addr   (icache_pc_addr),
		.pc_valid  (icache_valid_pc_addr),
		.stall     (icache_stall),
		.dram_req  (icache_dram_req),
		.dram_ready(icache_dram_ready)
	);

	dcache_ctrl #(
		.NT   (NT),
		.LINES(DCACHE_LINES)
	) i_dcache (
		.clk       (clk),
		.reset     (reset),
		.mem_read  (dcache_mem_read),
		.mem_write (dcache_mem_write),
		.lane_valid(dcache_in_valid),
		.lane_addr (dcache_in_addr),
		.stall     (dcache_stall),
		.dram_req  (dcache_dram_req),
		.dram_ready(dcache_dram_ready)
	);

endmodule

// File: hw/dcache_ctrl.sv
module dcache_ctrl #(
	parameter int NT    = 4,
	parameter int LINES = 16
) (
	input  logic                 clk,
	input  logic                 reset,
	input  cache_pkg::mem_op_t   mem_read,
	input  cache_pkg::mem_op_t   mem_write,
	input  logic [NT-1:0]        lane_valid,
	input  cache_pkg::addr_t     lane_addr [NT],
	output logic                 stall,
	output cache_pkg::dram_req_t dram_req,
	input  logic                 dram_ready
);
	import cache_pkg::*;

	localparam int LANE_BITS = (NT > 1) ? $clog2(NT) : 1;

	typedef logic [LANE_BITS-1:0] lane_t;

	typedef enum logic [1:0] {
		LOOKUP,
		REQUEST,
		WAIT
	} state_t;

	state_t        state;
	state_t        state_next;
	logic [NT-1:0] lane_req;
	logic [NT-1:0] hit;
	logic [NT-1:0] done;
	logic [NT-1:0] need;
	lane_t         sel;
	lane_t         sel_next;
	logic          fill;

	// A store allocates just like a load.
	assign lane_req = ((mem_read != MEM_NONE) || (mem_write != MEM_NONE)) ? lane_valid : '0;
	assign need     = lane_req & ~hit & ~done;
	assign fill     = (state == WAIT) && dram_ready;

	cache_tag_store #(
		.LINES(LINES),
		.PORTS(NT)
	) i_tags (
		.clk        (clk),
		.reset      (reset),
		.lookup_addr(lane_addr),
		.hit        (hit),
		.fill       (fill),
		.fill_addr  (lane_addr[sel])
	);

	// Lowest lane still waiting on a fill.
	always_comb begin
		sel_next = '0;
		for (int i = NT - 1; i >= 0; i--) begin
			if (need[i])
				sel_next = lane_t'(i);
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			LOOKUP:  if (|need) state_next = REQUEST;
			REQUEST: state_next = WAIT;
			WAIT:    if (dram_ready) state_next = LOOKUP;
			default: state_next = LOOKUP;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= LOOKUP;
			done  <= '0;
			sel   <= '0;
		end else begin
			state <= state_next;
			if (state == LOOKUP) begin
				if (need == '0) begin
					done <= '0; // Request complete so the mask starts clean.
				end else begin
					done <= done | (lane_req & hit);
					sel  <= sel_next;
				end
			end else if (fill) begin
				done[sel] <= 1'b1; // Served even if a later lane evicts the block.
			end
		end
	end

	assign stall = (state != LOOKUP) || (|need);

	assign dram_req.valid      = (state == REQUEST);
	assign dram_req.block_addr = block_of(lane_addr[sel]);

endmodule

// File: hw/icache_ctrl.sv
module icache_ctrl #(
	parameter int LINES = 16
) (
	input  logic                 clk,
	input  logic                 reset,
	input  cache_pkg::addr_t     pc_addr,
	input  logic                 pc_valid,
	output logic                 stall,
	output cache_pkg::dram_req_t dram_req,
	input  logic                 dram_ready
);
	import cache_pkg::*;

	typedef enum logic [1:0] {
		LOOKUP,
		REQUEST,
		WAIT
	} state_t;

	state_t state;
	state_t state_next;
	addr_t  lookup [1];
	logic   hit;
	logic   miss;
	logic   fill;

	assign lookup[0] = pc_addr;
	assign miss      = pc_valid && !hit;
	assign fill      = (state == WAIT) && dram_ready;

	cache_tag_store #(
		.LINES(LINES),
		.PORTS(1)
	) i_tags (
		.clk        (clk),
		.reset      (reset),
		.lookup_addr(lookup),
		.hit        (hit),
		.fill       (fill),
		.fill_addr  (pc_addr) // Core holds the PC during the stall.
	);

	always_comb begin
		state_next = state;
		case (state)
			LOOKUP:  if (miss) state_next = REQUEST;
			REQUEST: state_next = WAIT;
			WAIT:    if (dram_ready) state_next = LOOKUP;
			default: state_next = LOOKUP;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= LOOKUP;
		else
			state <= state_next;
	end

	// Miss stalls in the same cycle.
	assign stall = (state != LOOKUP) || miss;

	assign dram_req.valid      = (state == REQUEST);
	assign dram_req.block_addr = block_of(pc_addr);

endmodule

// File: hw/cache_tag_store.sv
module cache_tag_store #(
	parameter int LINES = 16,
	parameter int PORTS = 1
) (
	input  logic             clk,
	input  logic             reset,
	input  cache_pkg::addr_t lookup_addr [PORTS],
	output logic [PORTS-1:0] hit,
	input  logic             fill,
	input  cache_pkg::addr_t fill_addr
);
	import cache_pkg::*;

	localparam int ADDR_BITS  = $bits(addr_t);
	localparam int INDEX_BITS = $clog2(LINES);
	localparam int TAG_BITS   = ADDR_BITS - OFFSET_BITS - INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0]   tag_t;

	tag_t             tags [LINES];
	logic [LINES-1:0] valid;

	index_t fill_index;
	tag_t   fill_tag;

	assign fill_index = fill_addr[OFFSET_BITS +: INDEX_BITS];
	assign fill_tag   = fill_addr[ADDR_BITS-1 -: TAG_BITS];

	// One comparator per lookup port.
	for (genvar p = 0; p < PORTS; p++) begin : g_port
		index_t idx;
		tag_t   tag;

		assign idx    = lookup_addr[p][OFFSET_BITS +: INDEX_BITS];
		assign tag    = lookup_addr[p][ADDR_BITS-1 -: TAG_BITS];
		assign hit[p] = valid[idx] && (tags[idx] == tag);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid <= '0;
		end else if (fill) begin
			valid[fill_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill)
			tags[fill_index] <= fill_tag; // Only meaningful once valid is set.
	end

endmodule

// File: hw/cache_pkg.sv
package cache_pkg;

	typedef logic [31:0] addr_t;

	// Memory operation encoding, shared by loads and stores.
	typedef enum logic [2:0] {
		MEM_LB   = 3'd0,
		MEM_LH   = 3'd1,
		MEM_LW   = 3'd2, // Also the fetch read.
		MEM_LBU  = 3'd4,
		MEM_LHU  = 3'd5,
		MEM_NONE = 3'd7
	} mem_op_t;

	// Store codes reuse the byte, half and word load values.
	localparam mem_op_t MEM_SB = MEM_LB;
	localparam mem_op_t MEM_SH = MEM_LH;
	localparam mem_op_t MEM_SW = MEM_LW;

	typedef struct packed {
		logic  valid;      // One-cycle strobe.
		addr_t block_addr; // Offset bits cleared.
	} dram_req_t;

	localparam int NT           = 4;
	localparam int ICACHE_LINES = 16;
	localparam int DCACHE_LINES = 16;
	localparam int BLOCK_BYTES  = 16;

	localparam int OFFSET_BITS = $clog2(BLOCK_BYTES);

	// Block base address of a byte address.
	function automatic addr_t block_of(addr_t addr);
		addr_t mask;
		mask = '1;
		mask = mask << OFFSET_BITS;
		return addr & mask;
	endfunction

endpackage
